/* rob_macros.svh */
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// dispatch and retire width
`define NUM_SUPER 2

// reorder buffer depth
`define NUM_ROB 16

// register file sizes
`define NUM_ARCH 32
`define NUM_PHYS 64

`endif

/* rob_pkg.sv */
`default_nettype none
`include "rob_macros.svh"

package rob_pkg;

  typedef logic [$clog2(`NUM_ROB)-1:0]  rob_idx_t;
  typedef logic [$clog2(`NUM_ARCH)-1:0] arch_idx_t;
  typedef logic [$clog2(`NUM_PHYS)-1:0] phys_idx_t;

  // one window slot of 20 bits
  typedef struct packed {
    logic      valid;
    logic      complete;
    logic      halt;
    arch_idx_t dest_idx;
    phys_idx_t t_idx;
    phys_idx_t told_idx;
  } rob_entry_t;

endpackage

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module reorder_buffer
  import rob_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_fire,
  input  arch_idx_t [`NUM_SUPER-1:0]     dispatch_dest,
  input  logic      [`NUM_SUPER-1:0]     dispatch_halt,
  input  phys_idx_t [`NUM_SUPER-1:0]     alloc_t,
  input  phys_idx_t [`NUM_SUPER-1:0]     told,
  input  logic      [`NUM_SUPER-1:0]     complete_en,
  input  rob_idx_t  [`NUM_SUPER-1:0]     complete_idx,
  input  logic                           rollback_en,
  input  rob_idx_t                       rollback_idx,
  output logic                           space_ok,
  output rob_idx_t  [`NUM_SUPER-1:0]     dispatch_rob_idx,
  output logic      [`NUM_SUPER-1:0]     retire_en,
  output arch_idx_t [`NUM_SUPER-1:0]     retire_dest,
  output phys_idx_t [`NUM_SUPER-1:0]     retire_t,
  output phys_idx_t [`NUM_SUPER-1:0]     retire_told,
  output logic      [`NUM_SUPER-1:0]     halt_out,
  output logic                           recover
);

  localparam logic IDLE    = 1'b0;
  localparam logic RECOVER = 1'b1;

  rob_entry_t entry_q [`NUM_ROB];
  rob_entry_t entry_n [`NUM_ROB];

  rob_idx_t head_q, head_n;
  rob_idx_t tail_q, tail_n;
  rob_idx_t head_p1, tail_p1, tail_m1, tail_m2;
  rob_idx_t branch_q, branch_p1, branch_ofs;
  rob_idx_t [`NUM_SUPER-1:0] slot_idx;
  logic [`NUM_SUPER-1:0] slot_ready;
  logic state_q, state_n;
  logic mispredict;
  logic drained;

  assign head_p1    = head_q + 1'b1;
  assign tail_p1    = tail_q + 1'b1;
  assign tail_m1    = tail_q - 1'b1;
  assign tail_m2    = tail_q - 2'd2;
  assign branch_p1  = branch_q + 1'b1;
  assign branch_ofs = rollback_idx - head_q;
  assign slot_idx   = {head_p1, head_q};

  assign mispredict = rollback_en && entry_q[rollback_idx].valid;

  // branch itself has left the window
  assign drained = (head_q == branch_p1) && !entry_q[branch_q].valid;
  assign recover = (state_q == RECOVER) && drained;

  // a halt near the tail stops dispatch for good
  assign space_ok = (state_q == IDLE) && !entry_q[tail_q].valid && !entry_q[tail_p1].valid &&
                    !entry_q[tail_m1].halt && !entry_q[tail_m2].halt;

  assign dispatch_rob_idx = {tail_p1, tail_q};

  assign slot_ready[0] = entry_q[head_q].valid && entry_q[head_q].complete;
  assign slot_ready[1] = entry_q[head_p1].valid && entry_q[head_p1].complete;
  assign retire_en[0]  = slot_ready[0] && !rollback_en;
  assign retire_en[1]  = (&slot_ready) && !rollback_en;

  always_comb begin
    for (int k = 0; k < `NUM_SUPER; k++) begin
      retire_dest[k] = entry_q[slot_idx[k]].dest_idx;
      retire_t[k]    = entry_q[slot_idx[k]].t_idx;
      retire_told[k] = entry_q[slot_idx[k]].told_idx;
      halt_out[k]    = retire_en[k] && entry_q[slot_idx[k]].halt;
    end
  end

  always_comb begin
    entry_n = entry_q;
    head_n  = head_q;
    tail_n  = tail_q;
    for (int k = 0; k < `NUM_SUPER; k++) begin
      if (complete_en[k]) begin
        entry_n[complete_idx[k]].complete = 1'b1;
      end
    end
    for (int k = 0; k < `NUM_SUPER; k++) begin
      if (retire_en[k]) begin
        entry_n[slot_idx[k]].valid = 1'b0;
        head_n = head_n + 1'b1;
      end
    end
    if (dispatch_fire) begin
      for (int k = 0; k < `NUM_SUPER; k++) begin
        entry_n[dispatch_rob_idx[k]] = '{valid: 1'b1, complete: 1'b0, halt: dispatch_halt[k],
                                         dest_idx: dispatch_dest[k], t_idx: alloc_t[k],
                                         told_idx: told[k]};
      end
      tail_n = tail_q + 2'd2;
    end
    // keep head up to the branch, drop everything younger
    if (mispredict) begin
      for (int i = 0; i < `NUM_ROB; i++) begin
        if (rob_idx_t'(rob_idx_t'(i) - head_q) > branch_ofs) begin
          entry_n[i].valid = 1'b0;
        end
      end
      tail_n = rollback_idx + 1'b1;
    end
  end

  always_comb begin
    state_n = state_q;
    if (mispredict) begin
      state_n = RECOVER;
    end else if (recover) begin
      state_n = IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      state_q <= IDLE;
      for (int i = 0; i < `NUM_ROB; i++) begin
        entry_q[i].valid    <= 1'b0;
        entry_q[i].complete <= 1'b0;
        entry_q[i].halt     <= 1'b0;
      end
    end else begin
      head_q  <= head_n;
      tail_q  <= tail_n;
      state_q <= state_n;
      entry_q <= entry_n;
    end
  end

  always_ff @(posedge clock) begin
    if (mispredict) begin
      branch_q <= rollback_idx;
    end
  end

endmodule

`default_nettype wire

/* free_list.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module free_list
  import rob_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_fire,
  input  logic      [`NUM_SUPER-1:0]     retire_en,
  input  phys_idx_t [`NUM_SUPER-1:0]     retire_told,
  input  logic                           recover,
  input  logic      [`NUM_PHYS-1:0]      arch_used,
  output phys_idx_t [`NUM_SUPER-1:0]     alloc_t,
  output logic                           alloc_ok
);

  logic [`NUM_PHYS-1:0] free_q, free_n;
  logic [`NUM_PHYS-1:0] rest;

  // priority encoder where the lowest set bit wins
  function automatic phys_idx_t lowest_set(input logic [`NUM_PHYS-1:0] vec);
    phys_idx_t idx;
    idx = '0;
    for (int i = `NUM_PHYS-1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = phys_idx_t'(i);
      end
    end
    return idx;
  endfunction

  assign alloc_t[0] = lowest_set(free_q);

  // second pick skips the first
  always_comb begin
    rest = free_q;
    rest[alloc_t[0]] = 1'b0;
  end

  assign alloc_t[1] = lowest_set(rest);
  assign alloc_ok   = |rest;

  always_comb begin
    free_n = free_q;
    if (dispatch_fire) begin
      free_n[alloc_t[0]] = 1'b0;
      free_n[alloc_t[1]] = 1'b0;
    end
    for (int k = 0; k < `NUM_SUPER; k++) begin
      if (retire_en[k]) begin
        free_n[retire_told[k]] = 1'b1;
      end
    end
    if (recover) begin
      free_n = ~arch_used;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free_q <= {{(`NUM_PHYS-`NUM_ARCH){1'b1}}, {`NUM_ARCH{1'b0}}};
    end else begin
      free_q <= free_n;
    end
  end

endmodule

`default_nettype wire

/* map_table.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module map_table
  import rob_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_fire,
  input  arch_idx_t [`NUM_SUPER-1:0]     dispatch_dest,
  input  phys_idx_t [`NUM_SUPER-1:0]     alloc_t,
  input  logic                           recover,
  input  phys_idx_t [`NUM_ARCH-1:0]      arch_table,
  output phys_idx_t [`NUM_SUPER-1:0]     told
);

  phys_idx_t [`NUM_ARCH-1:0] map_q;

  assign told[0] = map_q[dispatch_dest[0]];
  // younger one sees the older one's new register
  assign told[1] = (dispatch_dest[1] == dispatch_dest[0]) ? alloc_t[0] :
                   map_q[dispatch_dest[1]];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `NUM_ARCH; r++) begin
        map_q[r] <= phys_idx_t'(r);
      end
    end else if (recover) begin
      map_q <= arch_table;
    end else if (dispatch_fire) begin
      map_q[dispatch_dest[0]] <= alloc_t[0];
      map_q[dispatch_dest[1]] <= alloc_t[1];
    end
  end

endmodule

`default_nettype wire

/* arch_map.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module arch_map
  import rob_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  logic      [`NUM_SUPER-1:0]     retire_en,
  input  arch_idx_t [`NUM_SUPER-1:0]     retire_dest,
  input  phys_idx_t [`NUM_SUPER-1:0]     retire_t,
  output phys_idx_t [`NUM_ARCH-1:0]      arch_table,
  output logic      [`NUM_PHYS-1:0]      arch_used
);

  // older slot first so the younger write lands last
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `NUM_ARCH; r++) begin
        arch_table[r] <= phys_idx_t'(r);
      end
    end else begin
      for (int k = 0; k < `NUM_SUPER; k++) begin
        if (retire_en[k]) begin
          arch_table[retire_dest[k]] <= retire_t[k];
        end
      end
    end
  end

  always_comb begin
    arch_used = '0;
    for (int r = 0; r < `NUM_ARCH; r++) begin
      arch_used[arch_table[r]] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rename_retire_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module rename_retire_top
  import rob_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_valid,
  input  arch_idx_t [`NUM_SUPER-1:0]     dispatch_dest,
  input  logic      [`NUM_SUPER-1:0]     dispatch_halt,
  output logic                           dispatch_ready,
  output rob_idx_t  [`NUM_SUPER-1:0]     dispatch_rob_idx,
  output phys_idx_t [`NUM_SUPER-1:0]     dispatch_t,
  output phys_idx_t [`NUM_SUPER-1:0]     dispatch_told,
  input  logic      [`NUM_SUPER-1:0]     complete_en,
  input  rob_idx_t  [`NUM_SUPER-1:0]     complete_idx,
  input  logic                           rollback_en,
  input  rob_idx_t                       rollback_idx,
  output logic      [`NUM_SUPER-1:0]     retire_en,
  output arch_idx_t [`NUM_SUPER-1:0]     retire_dest,
  output phys_idx_t [`NUM_SUPER-1:0]     retire_t,
  output phys_idx_t [`NUM_SUPER-1:0]     retire_told,
  output logic      [`NUM_SUPER-1:0]     halt_out
);

  logic dispatch_fire;
  logic space_ok;
  logic alloc_ok;
  logic recover;
  phys_idx_t [`NUM_ARCH-1:0] arch_table;
  logic [`NUM_PHYS-1:0] arch_used;

  assign dispatch_ready = space_ok && alloc_ok;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;

  reorder_buffer rob_inst (
    .clock, .reset, .dispatch_fire, .dispatch_dest, .dispatch_halt,
    .alloc_t(dispatch_t), .told(dispatch_told), .complete_en, .complete_idx,
    .rollback_en, .rollback_idx, .space_ok, .dispatch_rob_idx, .retire_en,
    .retire_dest, .retire_t, .retire_told, .halt_out, .recover
  );

  free_list fl_inst (
    .clock, .reset, .dispatch_fire, .retire_en, .retire_told, .recover,
    .arch_used, .alloc_t(dispatch_t), .alloc_ok
  );

  map_table mt_inst (
    .clock, .reset, .dispatch_fire, .dispatch_dest, .alloc_t(dispatch_t),
    .recover, .arch_table, .told(dispatch_told)
  );

  arch_map am_inst (
    .clock, .reset, .retire_en, .retire_dest, .retire_t, .arch_table, .arch_used
  );

endmodule

`default_nettype wire

/* rename_retire_assert.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module rename_retire_assert (
  input logic                  clock,
  input logic                  reset,
  input logic [`NUM_SUPER-1:0] retire_en,
  input logic                  mispredict,
  input logic                  space_ok,
  input logic                  recover
);

  // flushed window has nothing left to retire on recovery
  nothing_retires_on_recover: assert property (@(posedge clock) disable iff (reset)
    recover |-> retire_en == '0)
    else $error("retirement in the cycle of recovery");

  rollback_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
    mispredict |=> !space_ok)
    else $error("space_ok high in the cycle after a rollback");

  recover_single_cycle: assert property (@(posedge clock) disable iff (reset)
    recover |=> !recover)
    else $error("recover held for more than one cycle");

endmodule

bind reorder_buffer rename_retire_assert rob_checks (
  .clock(clock), .reset(reset), .retire_en(retire_en), .mispredict(mispredict),
  .space_ok(space_ok), .recover(recover)
);

`default_nettype wire

/* rename_retire_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rob_macros.svh"

module rename_retire_tb
  import rob_pkg::*;
();

  localparam int NUM_ROWS   = 7;
  localparam int WAIT_LIMIT = 200;

  typedef struct packed {
    logic [3:0] pairs;
    logic       same_dest;
    logic       do_rollback;
    logic [3:0] branch_pos;
    logic       halt;
  } op_row_t;

  // pairs, same_dest (told bypass expected), do_rollback, branch_pos, halt
  localparam op_row_t OP_TABLE [NUM_ROWS] = '{
    '{4'd3, 1'b0, 1'b0, 4'd0, 1'b0},
    '{4'd2, 1'b1, 1'b0, 4'd0, 1'b0},
    '{4'd8, 1'b0, 1'b0, 4'd0, 1'b0},
    '{4'd5, 1'b0, 1'b1, 4'd3, 1'b0},
    '{4'd6, 1'b0, 1'b0, 4'd0, 1'b0},
    '{4'd4, 1'b1, 1'b1, 4'd6, 1'b0},
    '{4'd2, 1'b0, 1'b0, 4'd0, 1'b1}
  };
  string row_name [NUM_ROWS] = '{"rename_basic", "same_dest_bypass", "full_window",
                                 "rollback_mid", "register_reuse", "rollback_pairs",
                                 "halt_stop"};

  logic clock, reset, dispatch_valid, dispatch_ready, rollback_en;
  arch_idx_t [`NUM_SUPER-1:0] dispatch_dest, retire_dest;
  logic      [`NUM_SUPER-1:0] dispatch_halt, complete_en, retire_en, halt_out;
  rob_idx_t  [`NUM_SUPER-1:0] dispatch_rob_idx, complete_idx;
  rob_idx_t                   rollback_idx;
  phys_idx_t [`NUM_SUPER-1:0] dispatch_t, dispatch_told, retire_t, retire_told;

  // reference model
  phys_idx_t spec_map [`NUM_ARCH];
  phys_idx_t commit_map [`NUM_ARCH];
  logic [`NUM_PHYS-1:0] model_free, ever_alloc;
  rob_idx_t  model_tail;
  arch_idx_t q_dest [$];
  phys_idx_t q_t [$];
  phys_idx_t q_told [$];
  logic      q_halt [$];
  logic      q_done [$];
  rob_idx_t  q_rob [$];
  int reuse_count, halt_count;
  string test_name;
  logic [15:0] lfsr_state;

  rename_retire_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // taps 16, 14, 13, 11
  function automatic logic step_lfsr();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(step_lfsr());
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_phys(input string what, input phys_idx_t expected, input phys_idx_t actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_arch(input string what, input arch_idx_t expected, input arch_idx_t actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_rob(input string what, input rob_idx_t expected, input rob_idx_t actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %0b actual %0b", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!dispatch_ready) begin
      if (n == WAIT_LIMIT) begin
        $display("timeout in %s while waiting for dispatch_ready", test_name);
        abort_run();
      end
      @(negedge clock);
      n++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (q_dest.size() != 0) begin
      if (n == WAIT_LIMIT) begin
        $display("timeout in %s while waiting for retirement", test_name);
        abort_run();
      end
      @(negedge clock);
      n++;
    end
  endtask

  task automatic record_entry(input arch_idx_t d, input phys_idx_t t, input phys_idx_t old,
                              input logic h, input rob_idx_t idx);
    q_dest.push_back(d);
    q_t.push_back(t);
    q_told.push_back(old);
    q_halt.push_back(h);
    q_done.push_back(1'b0);
    q_rob.push_back(idx);
    model_free[t] = 1'b0;
    if (ever_alloc[t]) begin
      reuse_count++;
    end
    ever_alloc[t] = 1'b1;
  endtask

  task automatic dispatch_pair(input arch_idx_t d0, input arch_idx_t d1, input logic h1);
    phys_idx_t t0, t1, exp_told1;
    wait_ready();
    dispatch_valid   = 1'b1;
    dispatch_dest[0] = d0;
    dispatch_dest[1] = d1;
    dispatch_halt    = {h1, 1'b0};
    #1;
    t0 = dispatch_t[0];
    t1 = dispatch_t[1];
    exp_told1 = (d1 == d0) ? t0 : spec_map[d1];
    check_rob("rob_idx0", model_tail, dispatch_rob_idx[0]);
    check_rob("rob_idx1", rob_idx_t'(model_tail + 1'b1), dispatch_rob_idx[1]);
    check_phys("told0", spec_map[d0], dispatch_told[0]);
    check_phys("told1", exp_told1, dispatch_told[1]);
    check_bit("t0_free", 1'b1, model_free[t0]);
    check_bit("t1_free", 1'b1, model_free[t1]);
    check_bit("t_distinct", 1'b1, t0 != t1);
    record_entry(d0, t0, spec_map[d0], 1'b0, dispatch_rob_idx[0]);
    spec_map[d0] = t0;
    record_entry(d1, t1, spec_map[d1], h1, dispatch_rob_idx[1]);
    spec_map[d1] = t1;
    model_tail = rob_idx_t'(model_tail + 2'd2);
    @(negedge clock);
    dispatch_valid = 1'b0;
    dispatch_halt  = '0;
  endtask

  task automatic mark_done(input rob_idx_t idx);
    for (int i = 0; i < q_rob.size(); i++) begin
      if (q_rob[i] == idx) begin
        q_done[i] = 1'b1;
      end
    end
  endtask

  // shuffled completion of two per cycle
  task automatic complete_pending();
    rob_idx_t order [$];
    rob_idx_t tmp;
    int j;
    for (int i = 0; i < q_rob.size(); i++) begin
      if (!q_done[i]) begin
        order.push_back(q_rob[i]);
      end
    end
    for (int i = order.size() - 1; i > 0; i--) begin
      j = random_bits(4) % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < order.size(); i += 2) begin
      complete_en     = 2'b01;
      complete_idx[0] = order[i];
      mark_done(order[i]);
      if (i + 1 < order.size()) begin
        complete_en[1]  = 1'b1;
        complete_idx[1] = order[i + 1];
        mark_done(order[i + 1]);
      end
      @(negedge clock);
      complete_en = '0;
    end
  endtask

  task automatic send_rollback(input int pos);
    rollback_en  = 1'b1;
    rollback_idx = q_rob[pos];
    model_tail   = rob_idx_t'(q_rob[pos] + 1'b1);
    while (q_rob.size() > pos + 1) begin
      void'(q_dest.pop_back());
      void'(q_t.pop_back());
      void'(q_told.pop_back());
      void'(q_halt.pop_back());
      void'(q_done.pop_back());
      void'(q_rob.pop_back());
    end
    @(negedge clock);
    rollback_en = 1'b0;
    check_bit("ready_after_rollback", 1'b0, dispatch_ready);
  endtask

  // speculative state falls back to the committed map
  task automatic restore_model();
    model_free = '1;
    for (int r = 0; r < `NUM_ARCH; r++) begin
      spec_map[r] = commit_map[r];
      model_free[commit_map[r]] = 1'b0;
    end
  endtask

  task automatic probe_map();
    for (int r = 0; r < `NUM_ARCH; r += 2) begin
      dispatch_dest[0] = arch_idx_t'(r);
      dispatch_dest[1] = arch_idx_t'(r + 1);
      #1;
      check_phys("map_told0", commit_map[r], dispatch_told[0]);
      check_phys("map_told1", commit_map[r + 1], dispatch_told[1]);
      @(negedge clock);
    end
  endtask

  task automatic follow_retire();
    if (retire_en[1] && !retire_en[0]) begin
      $display("younger slot retired while the older slot did not in %s", test_name);
      abort_run();
    end
    for (int k = 0; k < `NUM_SUPER; k++) begin
      if (retire_en[k]) begin
        if (q_dest.size() == 0) begin
          $display("retirement with nothing left in flight in %s", test_name);
          abort_run();
        end
        check_arch("retire_dest", q_dest[0], retire_dest[k]);
        check_phys("retire_t", q_t[0], retire_t[k]);
        check_phys("retire_told", q_told[0], retire_told[k]);
        check_bit("retire_done", 1'b1, q_done[0]);
        check_bit("halt_out", q_halt[0], halt_out[k]);
        if (halt_out[k]) begin
          halt_count++;
        end
        commit_map[q_dest[0]] = q_t[0];
        model_free[q_told[0]] = 1'b1;
        void'(q_dest.pop_front());
        void'(q_t.pop_front());
        void'(q_told.pop_front());
        void'(q_halt.pop_front());
        void'(q_done.pop_front());
        void'(q_rob.pop_front());
      end else begin
        check_bit("halt_idle", 1'b0, halt_out[k]);
      end
    end
  endtask

  always @(negedge clock) begin
    #1;
    if (!reset) begin
      follow_retire();
    end
  end

  initial begin
    op_row_t row;
    arch_idx_t d0, d1;
    lfsr_state     = 16'd55;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_halt  = '0;
    complete_en    = '0;
    complete_idx   = '0;
    rollback_en    = 1'b0;
    rollback_idx   = '0;
    reuse_count    = 0;
    halt_count     = 0;
    model_tail     = '0;
    test_name      = "reset";
    for (int r = 0; r < `NUM_ARCH; r++) begin
      spec_map[r]   = phys_idx_t'(r);
      commit_map[r] = phys_idx_t'(r);
    end
    model_free = {{(`NUM_PHYS-`NUM_ARCH){1'b1}}, {`NUM_ARCH{1'b0}}};
    ever_alloc = ~model_free;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_bit("ready", 1'b1, dispatch_ready);
    check_bit("retire_en0", 1'b0, retire_en[0]);
    check_bit("retire_en1", 1'b0, retire_en[1]);
    probe_map();

    // empty window so this rollback must be ignored
    test_name    = "ignored_rollback";
    rollback_en  = 1'b1;
    rollback_idx = rob_idx_t'(5);
    @(negedge clock);
    rollback_en = 1'b0;
    check_bit("ready", 1'b1, dispatch_ready);

    for (int i = 0; i < NUM_ROWS; i++) begin
      row = OP_TABLE[i];
      test_name = row_name[i];
      for (int p = 0; p < int'(row.pairs); p++) begin
        d0 = arch_idx_t'(random_bits(5));
        d1 = row.same_dest ? d0 : arch_idx_t'(random_bits(5));
        dispatch_pair(d0, d1, row.halt && (p == int'(row.pairs) - 1));
      end
      if (row.halt) begin
        check_bit("ready_after_halt", 1'b0, dispatch_ready);
      end
      if (row.do_rollback) begin
        send_rollback(int'(row.branch_pos));
      end
      complete_pending();
      wait_drain();
      if (row.do_rollback) begin
        wait_ready();
        restore_model();
        probe_map();
      end
      if (row.halt) begin
        check_bit("ready_after_halt_retired", 1'b0, dispatch_ready);
        check_bit("halt_retired", 1'b1, halt_count == 1);
      end
    end

    test_name = "reuse_total";
    check_bit("freed_reg_reused", 1'b1, reuse_count > 0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
rob_pkg.sv
reorder_buffer.sv
free_list.sv
map_table.sv
arch_map.sv
rename_retire_top.sv
rename_retire_assert.sv
rename_retire_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rename_retire_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash or a failed assertion also counts as a failing run
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
